// File: common/ls_params.svh
/* Load/store subsystem widths and depths */

`ifndef LS_PARAMS_SVH
`define LS_PARAMS_SVH

// Data path and address width of the processor
`define LS_DATA_W 32

// Register select width, giving eight registers
`define LS_REG_SEL_W 3

// Local data memory word-address width, 256 words
`define LS_DMEM_AW 8

// Width of one load/store operation word
`define LS_OP_W 15

`endif

// File: common/ls_pkg.sv
/* Load/store types */
`default_nettype none
`include "ls_params.svh"

package ls_pkg;

  // Operation word from the driver
  // A word access extends the offset with the half bit as its top bit
  typedef struct packed {
    logic                     store;
    logic                     upd;
    logic                     word;
    logic                     half;
    logic [4:0]               ofs;
    logic [`LS_REG_SEL_W-1:0] ptr_sel;
    logic [`LS_REG_SEL_W-1:0] data_sel;
  } ls_op_t;

  // No-wait local bus request, addr holds the word address
  typedef struct packed {
    logic                 valid;
    logic                 wr;
    logic [`LS_DATA_W-1:0] addr;
    logic [3:0]           mask;
    logic [`LS_DATA_W-1:0] wdata;
  } ls_req_t;

  // One register file write
  typedef struct packed {
    logic                     valid;
    logic [`LS_REG_SEL_W-1:0] sel;
    logic [`LS_DATA_W-1:0]    data;
  } ls_wb_t;

  // Memory word seen either as bytes or as halfwords
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
  } ls_word_u;

  // Posted remote store, addr is word aligned
  typedef struct packed {
    logic [`LS_DATA_W-1:0] addr;
    logic [3:0]           strb;
    logic [`LS_DATA_W-1:0] data;
  } ls_rmt_wr_t;

endpackage

`default_nettype wire

// File: load_store/ls_unit.sv
/* Load/store unit */
`timescale 1ns/100ps
`default_nettype none
`include "ls_params.svh"

module ls_unit
  import ls_pkg::*;
(
  input  wire logic                     CLK,
  input  wire logic                     RST,
  input  wire logic                     op_valid,
  input  wire ls_op_t                   op,
  input  wire logic [`LS_DATA_W-1:0]    ptr,
  input  wire logic [`LS_DATA_W-1:0]    store_data,
  input  wire ls_word_u                 rd_data,
  input  wire logic                     rmt_full,
  output logic [`LS_REG_SEL_W-1:0]      ptr_sel,
  output logic [`LS_REG_SEL_W-1:0]      store_sel,
  output ls_req_t                       req,
  output logic                          rmt_push,
  output ls_rmt_wr_t                    rmt_wr,
  output ls_wb_t                        ptr_wb,
  output ls_wb_t                        load_wb
);

  // Load tag that follows a local load until its data returns
  typedef struct packed {
    logic                     valid;
    logic                     word;
    logic                     half;
    logic [1:0]               lane;
    logic [`LS_REG_SEL_W-1:0] sel;
  } ld_tag_t;

  logic                  is_half;
  logic                  remote;
  logic [`LS_DATA_W-1:0] addr_ofs;
  logic [`LS_DATA_W-1:0] addr_adj;
  logic [`LS_DATA_W-1:0] addr_next;
  logic [`LS_DATA_W-1:0] addr_eff;
  logic [`LS_DATA_W-1:0] wr_data;
  logic [3:0]            mask;
  ld_tag_t               ld_d1;
  ld_tag_t               ld_d2;
  ld_tag_t               ld_d3;
  ls_word_u              rd_q;

  // The register file answers both selects in the same cycle
  assign ptr_sel   = op.ptr_sel;
  assign store_sel = op.data_sel;
  assign is_half   = !op.word && op.half;

  // Unsigned offset for plain accesses, signed adjustment for pointer updates
  always_comb
  begin
    if (op.word)
    begin
      addr_ofs = {{(`LS_DATA_W-8){1'b0}}, op.half, op.ofs, 2'b00};
      addr_adj = {{(`LS_DATA_W-8){op.half}}, op.half, op.ofs, 2'b00};
    end
    else if (op.half)
    begin
      addr_ofs = {{(`LS_DATA_W-6){1'b0}}, op.ofs, 1'b0};
      addr_adj = {{(`LS_DATA_W-6){op.ofs[4]}}, op.ofs, 1'b0};
    end
    else
    begin
      addr_ofs = {{(`LS_DATA_W-5){1'b0}}, op.ofs};
      addr_adj = {{(`LS_DATA_W-5){op.ofs[4]}}, op.ofs};
    end
  end

  assign addr_next = ptr + (op.upd ? addr_adj : addr_ofs);
  // Post-increment accesses at the old pointer, pre-decrement at the new one
  assign addr_eff  = (op.upd && !addr_adj[`LS_DATA_W-1]) ? ptr : addr_next;
  // Bit 31 selects the remote space
  assign remote    = addr_eff[`LS_DATA_W-1];

  // Store data goes to every lane and the mask picks the addressed one
  always_comb
  begin
    if (op.word)
    begin
      wr_data = store_data;
      mask    = 4'b1111;
    end
    else if (op.half)
    begin
      wr_data = {2{store_data[15:0]}};
      mask    = addr_eff[1] ? 4'b1100 : 4'b0011;
    end
    else
    begin
      wr_data = {4{store_data[7:0]}};
      mask    = 4'b0001 << addr_eff[1:0];
    end
  end

  // Request, pointer update and remote push all register one edge after acceptance
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      req      <= '0;
      ptr_wb   <= '0;
      rmt_push <= 1'b0;
      rmt_wr   <= '0;
    end
    else
    begin
      req.valid    <= op_valid && !remote;
      ptr_wb.valid <= op_valid && op.upd;
      // Remote loads are dropped here
      rmt_push     <= op_valid && remote && op.store;
      if (op_valid)
      begin
        req.wr      <= op.store;
        req.addr    <= {2'b00, addr_eff[`LS_DATA_W-1:2]};
        req.mask    <= mask;
        req.wdata   <= wr_data;
        ptr_wb.sel  <= op.ptr_sel;
        ptr_wb.data <= addr_next;
        rmt_wr.addr <= {addr_eff[`LS_DATA_W-1:2], 2'b00};
        rmt_wr.strb <= mask;
        rmt_wr.data <= wr_data;
      end
    end
  end

  // Three tag stages match the request, memory and capture registers
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      ld_d1 <= '0;
      ld_d2 <= '0;
      ld_d3 <= '0;
    end
    else
    begin
      ld_d1 <= '{valid: op_valid && !op.store && !remote, word: op.word, half: is_half,
                 lane: addr_eff[1:0], sel: op.data_sel};
      ld_d2 <= ld_d1;
      ld_d3 <= ld_d2;
    end
  end

  // Memory data is valid the cycle after its read registers
  always_ff @(posedge CLK)
  begin
    if (ld_d2.valid)
      rd_q <= rd_data;
  end

  // Pick the addressed lane and zero-extend it
  always_comb
  begin
    load_wb.valid = ld_d3.valid;
    load_wb.sel   = ld_d3.sel;
    if (ld_d3.word)
      load_wb.data = rd_q;
    else if (ld_d3.half)
      load_wb.data = {16'b0, rd_q.h[ld_d3.lane[1]]};
    else
      load_wb.data = {24'b0, rd_q.b[ld_d3.lane]};
  end

  // A push must come from an operation accepted while the queue had room
  a_no_push_full: assert property (@(posedge CLK) disable iff (RST)
    rmt_push |-> !$past(rmt_full));

  // Local loads return after a fixed three cycles
  a_load_latency: assert property (@(posedge CLK) disable iff (RST)
    op_valid && !op.store && !remote |-> ##3 load_wb.valid);

endmodule

`default_nettype wire

// File: source/ls_regfile.sv
/* Register file */
`timescale 1ns/100ps
`default_nettype none
`include "ls_params.svh"

module ls_regfile
  import ls_pkg::*;
(
  input  wire logic                     CLK,
  input  wire logic                     RST,
  input  wire logic [`LS_REG_SEL_W-1:0] ptr_sel,
  input  wire logic [`LS_REG_SEL_W-1:0] store_sel,
  input  wire ls_wb_t                   load_wb,
  input  wire ls_wb_t                   ptr_wb,
  input  wire ls_wb_t                   preload,
  output logic [`LS_DATA_W-1:0]         ptr,
  output logic [`LS_DATA_W-1:0]         store_data
);

  logic [`LS_DATA_W-1:0] regs [2**`LS_REG_SEL_W];

  // Later writes win, so load_wb beats ptr_wb which beats preload
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      regs <= '{default: '0};
    else
    begin
      if (preload.valid)
        regs[preload.sel] <= preload.data;
      if (ptr_wb.valid)
        regs[ptr_wb.sel] <= ptr_wb.data;
      if (load_wb.valid)
        regs[load_wb.sel] <= load_wb.data;
    end
  end

  // Both read ports are combinational
  assign ptr        = regs[ptr_sel];
  assign store_data = regs[store_sel];

endmodule

`default_nettype wire

// File: source/ls_dmem.sv
/* Local data memory */
`timescale 1ns/100ps
`default_nettype none
`include "ls_params.svh"

module ls_dmem
  import ls_pkg::*;
(
  input  wire logic    CLK,
  input  wire ls_req_t req,
  output ls_word_u     rd_data
);

  logic [3:0][7:0]         mem [2**`LS_DMEM_AW];
  logic [`LS_DMEM_AW-1:0] waddr;

  assign waddr = req.addr[`LS_DMEM_AW-1:0];

  // Only the lanes set in the mask are written
  always_ff @(posedge CLK)
  begin
    if (req.valid && req.wr)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (req.mask[i])
          mem[waddr][i] <= req.wdata[8*i +: 8];
      end
    end
  end

  // Reads are registered, giving the unit a fixed one-cycle latency
  always_ff @(posedge CLK)
  begin
    if (req.valid && !req.wr)
      rd_data.b <= mem[waddr];
  end

  // Upper word-address bits would alias onto the small array
  a_addr_range: assert property (@(posedge CLK)
    req.valid |-> req.addr[`LS_DATA_W-1:`LS_DMEM_AW] == '0);

endmodule

`default_nettype wire

// File: source/ls_remote_bridge.sv
/* Remote store bridge */
`timescale 1ns/100ps
`default_nettype none
`include "ls_params.svh"

module ls_remote_bridge
  import ls_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4
)
(
  input  wire logic              CLK,
  input  wire logic              RST,
  input  wire logic              push,
  input  wire ls_rmt_wr_t        wr,
  input  wire logic              awready,
  input  wire logic              wready,
  input  wire logic              bvalid,
  input  wire logic [1:0]        bresp,
  output logic                   full,
  output logic                   awvalid,
  output logic [`LS_DATA_W-1:0]  awaddr,
  output logic                   wvalid,
  output logic [`LS_DATA_W-1:0]  wdata,
  output logic [3:0]             wstrb,
  output logic                   bready
);

  // Depth is a power of two so the pointers wrap on their own
  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  ls_rmt_wr_t       queue [QUEUE_DEPTH];
  ls_rmt_wr_t       head;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             aw_done;
  logic             w_done;
  logic             pop;

  always_ff @(posedge CLK)
  begin
    if (push)
      queue[wr_ptr] <= wr;
  end

  assign head = queue[rd_ptr];
  // B may be taken at any time, the slave only answers after AW and W
  assign bready = 1'b1;
  assign pop    = bvalid && bready;

  // Full also counts a push in flight, so the driver sees it one op early
  assign full = (count == CNT_W'(QUEUE_DEPTH)) ||
                (push && count == CNT_W'(QUEUE_DEPTH - 1));

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + CNT_W'(push) - CNT_W'(pop);
      // Each channel finishes on its own handshake
      if (pop)
      begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end
      else
      begin
        if (awvalid && awready)
          aw_done <= 1'b1;
        if (wvalid && wready)
          w_done <= 1'b1;
      end
    end
  end

  assign awvalid = (count != '0) && !aw_done;
  assign wvalid  = (count != '0) && !w_done;
  assign awaddr  = head.addr;
  assign wdata   = head.data;
  assign wstrb   = head.strb;

  a_aw_stable: assert property (@(posedge CLK) disable iff (RST)
    awvalid && !awready |=> awvalid && $stable(awaddr));
  a_w_stable: assert property (@(posedge CLK) disable iff (RST)
    wvalid && !wready |=> wvalid && $stable(wdata));
  // Posted stores have no way to report a slave error
  a_bresp_okay: assert property (@(posedge CLK) disable iff (RST)
    bvalid |-> bresp == 2'b00);

endmodule

`default_nettype wire

// File: source/ls_subsys_top.sv
/* Load/store subsystem top */
`timescale 1ns/100ps
`default_nettype none
`include "ls_params.svh"

module ls_subsys_top
  import ls_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4
)
(
  input  wire logic             CLK,
  input  wire logic             RST,
  input  wire logic             op_valid,
  input  wire ls_op_t           op,
  output logic                  op_ready,
  input  wire ls_wb_t           preload,
  output ls_wb_t                load_wb,
  output ls_wb_t                ptr_wb,
  output logic                  awvalid,
  input  wire logic             awready,
  output logic [`LS_DATA_W-1:0] awaddr,
  output logic                  wvalid,
  input  wire logic             wready,
  output logic [`LS_DATA_W-1:0] wdata,
  output logic [3:0]            wstrb,
  input  wire logic             bvalid,
  output logic                  bready,
  input  wire logic [1:0]       bresp
);

  logic [`LS_REG_SEL_W-1:0] ptr_sel;
  logic [`LS_REG_SEL_W-1:0] store_sel;
  logic [`LS_DATA_W-1:0]    ptr;
  logic [`LS_DATA_W-1:0]    store_data;
  ls_req_t                  req;
  ls_word_u                 rd_data;
  logic                     rmt_push;
  ls_rmt_wr_t               rmt_wr;
  logic                     rmt_full;

  // The remote queue is the only source of back-pressure
  assign op_ready = !rmt_full;

  ls_unit i_unit (.CLK, .RST, .op_valid, .op, .ptr, .store_data, .rd_data, .rmt_full,
    .ptr_sel, .store_sel, .req, .rmt_push, .rmt_wr, .ptr_wb, .load_wb);

  ls_regfile i_regfile (.CLK, .RST, .ptr_sel, .store_sel, .load_wb, .ptr_wb, .preload,
    .ptr, .store_data);

  ls_dmem i_dmem (.CLK, .req, .rd_data);

  ls_remote_bridge #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_bridge (.CLK, .RST, .push(rmt_push),
    .wr(rmt_wr), .awready, .wready, .bvalid, .bresp, .full(rmt_full), .awvalid, .awaddr,
    .wvalid, .wdata, .wstrb, .bready);

endmodule

`default_nettype wire

// File: tests/axil_slave_model.sv
/* AXI4-Lite write slave model */
`timescale 1ns/100ps
`default_nettype none
`include "ls_params.svh"

module axil_slave_model
#(
  parameter int SEED = 32'h4d4d
)
(
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  stall,
  input  wire logic                  awvalid,
  input  wire logic [`LS_DATA_W-1:0] awaddr,
  output logic                       awready,
  input  wire logic                  wvalid,
  input  wire logic [`LS_DATA_W-1:0] wdata,
  input  wire logic [3:0]            wstrb,
  output logic                       wready,
  output logic                       bvalid,
  input  wire logic                  bready,
  output logic [1:0]                 bresp,
  output int                         write_count,
  output logic [`LS_DATA_W-1:0]      last_addr,
  output logic [`LS_DATA_W-1:0]      last_data,
  output logic [3:0]                 last_strb
);

  int                    seed;
  logic [31:0]           rnd;
  logic                  aw_got;
  logic                  w_got;
  logic [`LS_DATA_W-1:0] addr_q;
  logic [`LS_DATA_W-1:0] data_q;
  logic [3:0]            strb_q;

  initial
    seed = SEED;

  // A fresh random word each cycle gives the ready delays
  always @(posedge CLK)
    rnd <= $random(seed);

  // Every write is answered with OKAY
  assign bresp = 2'b00;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      awready     <= 1'b0;
      wready      <= 1'b0;
      bvalid      <= 1'b0;
      aw_got      <= 1'b0;
      w_got       <= 1'b0;
      addr_q      <= '0;
      data_q      <= '0;
      strb_q      <= '0;
      write_count <= 0;
      last_addr   <= '0;
      last_data   <= '0;
      last_strb   <= '0;
    end
    else
    begin
      // Ready stays low once its channel is taken for the current write
      awready <= !stall && rnd[0] && !aw_got && !(awvalid && awready);
      wready  <= !stall && rnd[1] && !w_got && !(wvalid && wready);
      if (awvalid && awready)
      begin
        aw_got <= 1'b1;
        addr_q <= awaddr;
      end
      if (wvalid && wready)
      begin
        w_got  <= 1'b1;
        data_q <= wdata;
        strb_q <= wstrb;
      end
      // The response goes out only after both address and data arrived
      if (bvalid && bready)
      begin
        bvalid      <= 1'b0;
        aw_got      <= 1'b0;
        w_got       <= 1'b0;
        write_count <= write_count + 1;
        last_addr   <= addr_q;
        last_data   <= data_q;
        last_strb   <= strb_q;
      end
      else if (aw_got && w_got)
        bvalid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_ls_subsys.sv
/* Load/store subsystem testbench */
`timescale 1ns/100ps
`default_nettype none
`include "ls_params.svh"

module tb_ls_subsys
  import ls_pkg::*;
();

  localparam int QUEUE_DEPTH = 4;
  // The tests need well under 600 cycles together
  localparam int TIMEOUT_CYCLES = 2000;
  localparam logic [1:0] SZ_BYTE = 2'd0;
  localparam logic [1:0] SZ_HALF = 2'd1;
  localparam logic [1:0] SZ_WORD = 2'd2;

  logic                  CLK;
  logic                  RST;
  logic                  op_valid;
  ls_op_t                op;
  logic                  op_ready;
  ls_wb_t                preload;
  ls_wb_t                load_wb;
  ls_wb_t                ptr_wb;
  logic                  awvalid;
  logic                  awready;
  logic [`LS_DATA_W-1:0] awaddr;
  logic                  wvalid;
  logic                  wready;
  logic [`LS_DATA_W-1:0] wdata;
  logic [3:0]            wstrb;
  logic                  bvalid;
  logic                  bready;
  logic [1:0]            bresp;
  logic                  stall;
  int                    wr_count;
  logic [`LS_DATA_W-1:0] last_addr;
  logic [`LS_DATA_W-1:0] last_data;
  logic [3:0]            last_strb;
  int                    seed;
  int                    errors;
  int                    tests_run;
  int                    cycles = 0;

  ls_subsys_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_dut (.CLK, .RST, .op_valid, .op, .op_ready,
    .preload, .load_wb, .ptr_wb, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
    .wstrb, .bvalid, .bready, .bresp);

  axil_slave_model #(.SEED(32'h4d4d)) i_slave (.CLK, .RST, .stall, .awvalid, .awaddr,
    .awready, .wvalid, .wdata, .wstrb, .wready, .bvalid, .bready, .bresp,
    .write_count(wr_count), .last_addr, .last_data, .last_strb);

  initial
  begin
    CLK = 1'b0;
    forever
      #50 CLK = ~CLK;
  end

  // Hard limit on the run in case a handshake never completes
  always @(posedge CLK)
  begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES)
    begin
      $display("ERROR: simulation timed out after %0d cycles", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  // Size 2 is a word, whose six-bit offset puts its top bit in the half field
  function automatic ls_op_t make_op(input logic store, input logic upd,
                                     input logic [1:0] size, input logic [5:0] ofs,
                                     input logic [2:0] ptr_sel, input logic [2:0] data_sel);
    ls_op_t o;
    o.store    = store;
    o.upd      = upd;
    o.word     = (size == SZ_WORD);
    o.half     = o.word ? ofs[5] : (size == SZ_HALF);
    o.ofs      = ofs[4:0];
    o.ptr_sel  = ptr_sel;
    o.data_sel = data_sel;
    return o;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge CLK);
    #10;
  endtask

  // Register write through the driver-side preload port
  task automatic write_reg(input logic [2:0] sel, input logic [31:0] data);
    @(posedge CLK);
    #10;
    preload = '{valid: 1'b1, sel: sel, data: data};
    @(posedge CLK);
    #10;
    preload.valid = 1'b0;
  endtask

  // Returns 10 ns after the edge that accepted the operation
  task automatic issue_op(input ls_op_t o);
    int waited;
    waited = 0;
    @(posedge CLK);
    #10;
    while (!op_ready && waited < 100)
    begin
      @(posedge CLK);
      #10;
      waited++;
    end
    if (!op_ready)
      report_error("op_ready stayed low, operation not issued");
    else
    begin
      op       = o;
      op_valid = 1'b1;
      @(posedge CLK);
      #10;
      op_valid = 1'b0;
    end
  endtask

  // Cycle 1 is the one right after the accepting edge
  task automatic load_and_check(input string name, input ls_op_t o, input logic [31:0] exp);
    int lat;
    lat = 1;
    issue_op(o);
    while (!load_wb.valid && lat < 8)
    begin
      @(posedge CLK);
      #10;
      lat++;
    end
    if (!load_wb.valid)
      report_error({name, ": no load writeback arrived"});
    else
    begin
      if (lat != 3)
        report_mismatch({name, " latency"}, 32'd3, lat);
      if (load_wb.sel !== o.data_sel)
        report_mismatch({name, " destination"}, o.data_sel, load_wb.sel);
      if (load_wb.data !== exp)
        report_mismatch({name, " data"}, exp, load_wb.data);
    end
    idle_cycles(4);
  endtask

  task automatic wait_remote_write(input int n);
    int waited;
    waited = 0;
    while (wr_count != n && waited < 60)
    begin
      @(posedge CLK);
      #10;
      waited++;
    end
    if (wr_count != n)
      report_error("remote write did not complete on the AXI side");
  endtask

  // Every valid is low and both ready outputs are high once reset is released
  task automatic idle_after_reset();
    tests_run++;
    if (op_ready !== 1'b1)
      report_mismatch("idle_after_reset op_ready", 32'd1, op_ready);
    if (bready !== 1'b1)
      report_mismatch("idle_after_reset bready", 32'd1, bready);
    if (load_wb.valid !== 1'b0 || ptr_wb.valid !== 1'b0)
      report_error("idle_after_reset: a register writeback is valid after reset");
    if (awvalid !== 1'b0 || wvalid !== 1'b0)
      report_error("idle_after_reset: an AXI valid is high after reset");
  endtask

  task automatic word_round_trip();
    logic [31:0] data;
    data = $random(seed);
    tests_run++;
    write_reg(3'd1, 32'h0000_0100);
    write_reg(3'd2, data);
    issue_op(make_op(1'b1, 1'b0, SZ_WORD, 6'd5, 3'd1, 3'd2));
    idle_cycles(4);
    load_and_check("word_round_trip", make_op(1'b0, 1'b0, SZ_WORD, 6'd5, 3'd1, 3'd3), data);
  endtask

  task automatic byte_half_lanes();
    logic [31:0] word;
    int          k;
    word = 32'hA1B2_C3D4;
    tests_run++;
    write_reg(3'd1, 32'h0000_0200);
    write_reg(3'd2, word);
    issue_op(make_op(1'b1, 1'b0, SZ_WORD, 6'd0, 3'd1, 3'd2));
    idle_cycles(4);
    for (k = 0; k < 4; k++)
      load_and_check("byte_half_lanes byte", make_op(1'b0, 1'b0, SZ_BYTE, 6'(k), 3'd1, 3'd3),
        (word >> (8 * k)) & 32'h0000_00ff);
    // Halfword offsets scale by two
    for (k = 0; k < 2; k++)
      load_and_check("byte_half_lanes half", make_op(1'b0, 1'b0, SZ_HALF, 6'(k), 3'd1, 3'd3),
        (word >> (16 * k)) & 32'h0000_ffff);
    // Byte store at offset 1 must hit lane 1 only
    write_reg(3'd4, 32'h0000_005E);
    issue_op(make_op(1'b1, 1'b0, SZ_BYTE, 6'd1, 3'd1, 3'd4));
    idle_cycles(4);
    load_and_check("byte_half_lanes masked", make_op(1'b0, 1'b0, SZ_WORD, 6'd0, 3'd1, 3'd3),
      {word[31:16], 8'h5E, word[7:0]});
  endtask

  task automatic pointer_update();
    logic [31:0] x;
    logic [31:0] y;
    x = $random(seed);
    y = $random(seed);
    tests_run++;
    write_reg(3'd5, 32'h0000_0300);
    write_reg(3'd6, x);
    write_reg(3'd7, y);
    // Post-increment by two words stores at the old pointer
    issue_op(make_op(1'b1, 1'b1, SZ_WORD, 6'd2, 3'd5, 3'd6));
    if (ptr_wb.valid !== 1'b1 || ptr_wb.sel !== 3'd5)
      report_error("pointer_update: no writeback of register 5 after post-increment");
    if (ptr_wb.data !== 32'h0000_0308)
      report_mismatch("pointer_update post-increment", 32'h0000_0308, ptr_wb.data);
    idle_cycles(4);
    // Offset of all ones is minus one word, stored at the new pointer
    issue_op(make_op(1'b1, 1'b1, SZ_WORD, 6'h3F, 3'd5, 3'd7));
    if (ptr_wb.data !== 32'h0000_0304)
      report_mismatch("pointer_update pre-decrement", 32'h0000_0304, ptr_wb.data);
    idle_cycles(4);
    write_reg(3'd1, 32'h0000_0300);
    load_and_check("pointer_update old pointer", make_op(1'b0, 1'b0, SZ_WORD, 6'd0, 3'd1, 3'd3),
      x);
    load_and_check("pointer_update new pointer", make_op(1'b0, 1'b0, SZ_WORD, 6'd1, 3'd1, 3'd3),
      y);
    // A byte adjustment of -16 is not scaled
    issue_op(make_op(1'b1, 1'b1, SZ_BYTE, 6'h10, 3'd5, 3'd6));
    if (ptr_wb.data !== 32'h0000_02F4)
      report_mismatch("pointer_update byte pre-decrement", 32'h0000_02F4, ptr_wb.data);
    idle_cycles(4);
  endtask

  task automatic unsigned_offset();
    logic [31:0] z;
    z = $random(seed);
    tests_run++;
    write_reg(3'd1, 32'h0000_0340);
    write_reg(3'd2, z);
    write_reg(3'd3, 32'h0000_03B0);
    // Offset 32 words lands at 0x3C0, the top offset bit counts as magnitude
    issue_op(make_op(1'b1, 1'b0, SZ_WORD, 6'h20, 3'd1, 3'd2));
    if (ptr_wb.valid !== 1'b0)
      report_mismatch("unsigned_offset ptr_wb valid", 32'd0, ptr_wb.valid);
    idle_cycles(4);
    // 0x3B0 plus 17 is byte 1 of the same word
    load_and_check("unsigned_offset byte", make_op(1'b0, 1'b0, SZ_BYTE, 6'h11, 3'd3, 3'd4),
      (z >> 8) & 32'h0000_00ff);
    load_and_check("unsigned_offset word", make_op(1'b0, 1'b0, SZ_WORD, 6'h20, 3'd1, 3'd4), z);
  endtask

  task automatic remote_store();
    logic [31:0] v;
    logic [31:0] d;
    int          base;
    logic        seen;
    v = $random(seed);
    d = $random(seed);
    seen = 1'b0;
    tests_run++;
    write_reg(3'd1, 32'h8000_0010);
    write_reg(3'd2, d);
    write_reg(3'd3, 32'h0000_0010);
    write_reg(3'd4, v);
    // Local word at the address the remote one would alias onto
    issue_op(make_op(1'b1, 1'b0, SZ_WORD, 6'd0, 3'd3, 3'd4));
    idle_cycles(4);
    base = wr_count;
    issue_op(make_op(1'b1, 1'b0, SZ_BYTE, 6'd1, 3'd1, 3'd2));
    wait_remote_write(base + 1);
    if (last_addr !== 32'h8000_0010)
      report_mismatch("remote_store address", 32'h8000_0010, last_addr);
    if (last_strb !== 4'b0010)
      report_mismatch("remote_store strobe", 32'h2, last_strb);
    if (last_data !== {4{d[7:0]}})
      report_mismatch("remote_store data", {4{d[7:0]}}, last_data);
    idle_cycles(4);
    load_and_check("remote_store local word", make_op(1'b0, 1'b0, SZ_WORD, 6'd0, 3'd3, 3'd5), v);
    // A remote load is dropped, so nothing may come back
    issue_op(make_op(1'b0, 1'b0, SZ_WORD, 6'd0, 3'd1, 3'd5));
    repeat (6)
    begin
      if (load_wb.valid)
        seen = 1'b1;
      @(posedge CLK);
      #10;
    end
    if (seen)
      report_error("remote_store: a remote load produced a load writeback");
    if (wr_count != base + 1)
      report_error("remote_store: a remote load produced an AXI write");
  endtask

  task automatic back_pressure();
    logic [31:0] pat [QUEUE_DEPTH+1];
    int          base;
    int          k;
    tests_run++;
    for (k = 0; k <= QUEUE_DEPTH; k++)
      pat[k] = $random(seed);
    stall = 1'b1;
    base  = wr_count;
    write_reg(3'd1, 32'h8000_0100);
    for (k = 0; k < QUEUE_DEPTH; k++)
    begin
      write_reg(3'd2, pat[k]);
      issue_op(make_op(1'b1, 1'b0, SZ_WORD, 6'(k), 3'd1, 3'd2));
      if (op_ready !== (k + 1 < QUEUE_DEPTH))
        report_mismatch("back_pressure op_ready", (k + 1 < QUEUE_DEPTH), op_ready);
    end
    idle_cycles(4);
    if (op_ready !== 1'b0)
      report_mismatch("back_pressure op_ready held", 32'd0, op_ready);
    if (wr_count != base)
      report_error("back_pressure: a write completed while the slave stalled");
    write_reg(3'd2, pat[QUEUE_DEPTH]);
    stall = 1'b0;
    issue_op(make_op(1'b1, 1'b0, SZ_WORD, 6'(QUEUE_DEPTH), 3'd1, 3'd2));
    // Writes must leave the queue in issue order
    for (k = 0; k <= QUEUE_DEPTH; k++)
    begin
      wait_remote_write(base + k + 1);
      if (last_addr !== 32'h8000_0100 + 4 * k)
        report_mismatch("back_pressure address", 32'h8000_0100 + 4 * k, last_addr);
      if (last_data !== pat[k])
        report_mismatch("back_pressure data", pat[k], last_data);
    end
  endtask

  initial
  begin
    seed      = 32'h4d4d;
    errors    = 0;
    tests_run = 0;
    RST       = 1'b1;
    op_valid  = 1'b0;
    op        = '0;
    preload   = '0;
    stall     = 1'b0;
    repeat (8) @(posedge CLK);
    #10;
    RST = 1'b0;
    idle_after_reset();
    word_round_trip();
    byte_half_lanes();
    pointer_update();
    unsigned_offset();
    remote_store();
    back_pressure();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/ls_pkg.sv
load_store/ls_unit.sv
source/ls_regfile.sv
source/ls_dmem.sv
source/ls_remote_bridge.sv
source/ls_subsys_top.sv
tests/axil_slave_model.sv
tests/tb_ls_subsys.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the load/store subsystem testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_ls_subsys \
  -o tb_ls_subsys
./obj_dir/tb_ls_subsys 2>&1 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
grep -qF "*** TEST PASSED ***" sim.log
